//--- verilog/rv32i_types.sv
package rv32i_types;

    // datapath width of the core
    parameter int xlen = 32;

    // register numbers address x0 to x31
    parameter int reg_idx_bits = 5;

    // register-register ALU operations handled by the execution lanes
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5, // shift amount is the low 5 bits of operand b
        op_srl = 3'd6,
        op_slt = 3'd7  // signed compare, result is 1 or 0
    } alu_op_e;

endpackage : rv32i_types

//--- verilog/rob_pkg.sv
package rob_pkg;

    // one reorder entry holds {done, dest, value}, msb first
    parameter int rob_entry_bits = 1 + rv32i_types::reg_idx_bits + rv32i_types::xlen;

    parameter int rob_value_lsb = 0;
    parameter int rob_dest_lsb = rob_value_lsb + rv32i_types::xlen;
    parameter int rob_done_bit = rob_dest_lsb + rv32i_types::reg_idx_bits; // top bit of the entry

    // the commit unit waits one cycle after every pop so that the
    // read-out of the new tail pair has caught up
    typedef enum logic {
        cs_look   = 1'b0,
        cs_settle = 1'b1
    } commit_state_e;

endpackage : rob_pkg

//--- verilog/issue_if.sv
`timescale 1ns/100ps

interface issue_if #(
    parameter int DEPTH_BITS = 3
);
    import rv32i_types::*;

    logic valid; // high only in the cycle the pair is accepted
    alu_op_e op;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [reg_idx_bits-1:0] dest;
    logic [DEPTH_BITS-1:0] rob_idx; // queue entry that receives the result

    // lanes never stall, so there is no ready signal
    modport dispatcher (output valid, op, src_a, src_b, dest, rob_idx);
    modport lane (input valid, op, src_a, src_b, dest, rob_idx);

endinterface : issue_if

//--- verilog/circular_queue.sv
`timescale 1ns/100ps

module circular_queue #(
    parameter int WIDTH = 38,
    parameter int DEPTH = 8,
    parameter int DEPTH_BITS = 3
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic [WIDTH-1:0] in [2], // pair written at the head
    input logic [WIDTH-1:0] reg_in [2], // writeback values
    input logic [DEPTH_BITS-1:0] reg_select_in [2],
    input logic [DEPTH_BITS-1:0] reg_select_out [2],
    input logic [1:0] in_bitmask,
    input logic [1:0] out_bitmask,
    output logic empty,
    output logic full,
    output logic [WIDTH-1:0] out [2], // pair taken from the tail
    output logic [WIDTH-1:0] reg_out [2] // observed entries, one cycle late
);
    localparam logic [DEPTH_BITS:0] pair_step = (DEPTH_BITS + 1)'(2);

    logic [WIDTH-1:0] entries [DEPTH];
    logic [DEPTH_BITS:0] head; // extra msb tells a full queue from an empty one
    logic [DEPTH_BITS:0] tail;
    logic [DEPTH_BITS-1:0] head_lo;
    logic [DEPTH_BITS-1:0] head_hi;
    logic [DEPTH_BITS-1:0] tail_lo;
    logic [DEPTH_BITS-1:0] tail_hi;

    // pairs always start on an even slot, so the second slot never wraps
    assign head_lo = head[DEPTH_BITS-1:0];
    assign head_hi = head_lo + DEPTH_BITS'(1);
    assign tail_lo = tail[DEPTH_BITS-1:0];
    assign tail_hi = tail_lo + DEPTH_BITS'(1);

    assign empty = (head == tail);
    assign full = (head_lo == tail_lo) && (head[DEPTH_BITS] != tail[DEPTH_BITS]);

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) head <= head + pair_step; // push and pop may share a cycle
            if (pop) tail <= tail + pair_step;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (in_bitmask[k]) entries[reg_select_in[k]] <= reg_in[k];
            end
            // a fresh push overrides any writeback aimed at the same slot
            if (push) begin
                entries[head_lo] <= in[0];
                entries[head_hi] <= in[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out[0] <= entries[tail_lo];
            out[1] <= entries[tail_hi];
        end
    end

    // read-out holds its value when a lane of the mask is off
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_out[0] <= '0;
            reg_out[1] <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (out_bitmask[k]) reg_out[k] <= entries[reg_select_out[k]];
            end
        end
    end

    push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push while the queue is full");

    pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop while the queue is empty");

endmodule : circular_queue

//--- verilog/dispatch_unit.sv
`timescale 1ns/100ps

module dispatch_unit #(
    parameter int DEPTH_BITS = 3
) (
    input logic clk,
    input logic rst,
    input logic dispatch_valid,
    input rv32i_types::alu_op_e op0,
    input logic [rv32i_types::xlen-1:0] src_a0,
    input logic [rv32i_types::xlen-1:0] src_b0,
    input logic [rv32i_types::reg_idx_bits-1:0] dest0,
    input rv32i_types::alu_op_e op1,
    input logic [rv32i_types::xlen-1:0] src_a1,
    input logic [rv32i_types::xlen-1:0] src_b1,
    input logic [rv32i_types::reg_idx_bits-1:0] dest1,
    input logic full,
    output logic dispatch_ready,
    output logic push,
    output logic [rob_pkg::rob_entry_bits-1:0] in [2],
    issue_if.dispatcher issue0,
    issue_if.dispatcher issue1
);
    import rv32i_types::*;
    import rob_pkg::*;

    logic [DEPTH_BITS-1:0] head_idx; // mirrors the low bits of the queue head
    logic accept;

    assign dispatch_ready = !full;
    assign accept = dispatch_valid && !full;
    assign push = accept;

    always_ff @(posedge clk) begin
        if (rst) head_idx <= '0;
        else if (accept) head_idx <= head_idx + DEPTH_BITS'(2);
    end

    // new entries carry only the destination, done and value start cleared
    always_comb begin
        in[0] = '0;
        in[1] = '0;
        in[0][rob_dest_lsb +: reg_idx_bits] = dest0;
        in[1][rob_dest_lsb +: reg_idx_bits] = dest1;
    end

    assign issue0.valid = accept; // lane 0 takes the older instruction
    assign issue0.op = op0;
    assign issue0.src_a = src_a0;
    assign issue0.src_b = src_b0;
    assign issue0.dest = dest0;
    assign issue0.rob_idx = head_idx;

    assign issue1.valid = accept;
    assign issue1.op = op1;
    assign issue1.src_a = src_a1;
    assign issue1.src_b = src_b1;
    assign issue1.dest = dest1;
    assign issue1.rob_idx = head_idx + DEPTH_BITS'(1);

endmodule : dispatch_unit

//--- verilog/exec_lane.sv
`timescale 1ns/100ps

module exec_lane #(
    parameter int DEPTH_BITS = 3
) (
    input logic clk,
    input logic rst,
    issue_if.lane issue,
    output logic wb_valid,
    output logic [DEPTH_BITS-1:0] wb_idx,
    output logic [rob_pkg::rob_entry_bits-1:0] wb_entry
);
    import rv32i_types::*;
    import rob_pkg::*;

    logic [xlen-1:0] result;
    logic [4:0] shamt;
    logic less;

    assign shamt = issue.src_b[4:0]; // upper bits of b are ignored for shifts
    assign less = $signed(issue.src_a) < $signed(issue.src_b);

    always_comb begin
        case (issue.op)
            op_add: result = issue.src_a + issue.src_b;
            op_sub: result = issue.src_a - issue.src_b;
            op_and: result = issue.src_a & issue.src_b;
            op_or: result = issue.src_a | issue.src_b;
            op_xor: result = issue.src_a ^ issue.src_b;
            op_sll: result = issue.src_a << shamt;
            op_srl: result = issue.src_a >> shamt; // logical, zero fill
            op_slt: result = {{(xlen - 1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) wb_valid <= 1'b0;
        else wb_valid <= issue.valid;
    end

    // the whole entry is rebuilt so the destination survives the writeback
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            wb_idx <= issue.rob_idx;
            wb_entry[rob_done_bit] <= 1'b1;
            wb_entry[rob_dest_lsb +: reg_idx_bits] <= issue.dest;
            wb_entry[rob_value_lsb +: xlen] <= result;
        end
    end

    // back-to-back writebacks of one lane belong to consecutive pairs
    single_writeback: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && $past(wb_valid)) |-> (wb_idx == $past(wb_idx) + DEPTH_BITS'(2)))
        else $error("back-to-back writebacks do not target consecutive pairs");

endmodule : exec_lane

//--- verilog/commit_unit.sv
`timescale 1ns/100ps

module commit_unit #(
    parameter int DEPTH_BITS = 3
) (
    input logic clk,
    input logic rst,
    input logic [rob_pkg::rob_entry_bits-1:0] reg_out [2],
    input logic [rob_pkg::rob_entry_bits-1:0] out [2],
    input logic empty,
    output logic [DEPTH_BITS-1:0] reg_select_out [2],
    output logic [1:0] out_bitmask,
    output logic pop,
    output logic commit_valid,
    output logic [rv32i_types::reg_idx_bits-1:0] commit_dest0,
    output logic [rv32i_types::xlen-1:0] commit_value0,
    output logic [rv32i_types::reg_idx_bits-1:0] commit_dest1,
    output logic [rv32i_types::xlen-1:0] commit_value1
);
    import rv32i_types::*;
    import rob_pkg::*;

    commit_state_e state;
    logic [DEPTH_BITS-1:0] tail_idx; // tracks the queue tail in step with pop
    logic seen_nonempty; // read-out was taken while the tail pair was live
    logic pair_done;

    assign reg_select_out[0] = tail_idx;
    assign reg_select_out[1] = tail_idx + DEPTH_BITS'(1);
    assign out_bitmask = {2{!empty}};

    // done flags left over from the previous lap are ignored until the
    // read-out has been refreshed after the queue filled again
    assign pair_done = reg_out[0][rob_done_bit] && reg_out[1][rob_done_bit];
    assign pop = (state == cs_look) && seen_nonempty && !empty && pair_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cs_look;
            tail_idx <= '0;
            seen_nonempty <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            seen_nonempty <= !empty;
            commit_valid <= pop; // the popped pair lands on out at the same edge
            case (state)
                cs_look: begin
                    if (pop) begin
                        tail_idx <= tail_idx + DEPTH_BITS'(2);
                        state <= cs_settle;
                    end
                end
                cs_settle: state <= cs_look;
                default: state <= cs_look;
            endcase
        end
    end

    assign commit_dest0 = out[0][rob_dest_lsb +: reg_idx_bits];
    assign commit_value0 = out[0][rob_value_lsb +: xlen];
    assign commit_dest1 = out[1][rob_dest_lsb +: reg_idx_bits];
    assign commit_value1 = out[1][rob_value_lsb +: xlen];

    // the pair the queue hands over from its own tail must already be done
    pop_when_done: assert property (@(posedge clk) disable iff (rst)
        pop |=> (out[0][rob_done_bit] && out[1][rob_done_bit]))
        else $error("pair popped before both results were written back");

endmodule : commit_unit

//--- verilog/dual_issue_rob.sv
`timescale 1ns/100ps

module dual_issue_rob #(
    parameter int DEPTH = 8, // must be even and at least 4
    parameter int DEPTH_BITS = 3
) (
    input logic clk,
    input logic rst,
    input logic dispatch_valid,
    output logic dispatch_ready,
    input rv32i_types::alu_op_e op0,
    input logic [rv32i_types::xlen-1:0] src_a0,
    input logic [rv32i_types::xlen-1:0] src_b0,
    input logic [rv32i_types::reg_idx_bits-1:0] dest0,
    input rv32i_types::alu_op_e op1,
    input logic [rv32i_types::xlen-1:0] src_a1,
    input logic [rv32i_types::xlen-1:0] src_b1,
    input logic [rv32i_types::reg_idx_bits-1:0] dest1,
    output logic commit_valid,
    output logic [rv32i_types::reg_idx_bits-1:0] commit_dest0,
    output logic [rv32i_types::xlen-1:0] commit_value0,
    output logic [rv32i_types::reg_idx_bits-1:0] commit_dest1,
    output logic [rv32i_types::xlen-1:0] commit_value1
);
    import rob_pkg::*;

    logic push;
    logic pop;
    logic full;
    logic empty;
    logic [rob_entry_bits-1:0] q_in [2];
    logic [rob_entry_bits-1:0] q_out [2];
    logic [rob_entry_bits-1:0] wb_entry [2];
    logic [DEPTH_BITS-1:0] wb_idx [2];
    logic [1:0] wb_valid;
    logic [rob_entry_bits-1:0] rd_entry [2];
    logic [DEPTH_BITS-1:0] rd_idx [2];
    logic [1:0] rd_mask;

    issue_if #(.DEPTH_BITS(DEPTH_BITS)) issue0 ();
    issue_if #(.DEPTH_BITS(DEPTH_BITS)) issue1 ();

    dispatch_unit #(.DEPTH_BITS(DEPTH_BITS)) dispatch (
        .clk(clk), .rst(rst), .dispatch_valid(dispatch_valid),
        .op0(op0), .src_a0(src_a0), .src_b0(src_b0), .dest0(dest0),
        .op1(op1), .src_a1(src_a1), .src_b1(src_b1), .dest1(dest1),
        .full(full), .dispatch_ready(dispatch_ready), .push(push), .in(q_in),
        .issue0(issue0.dispatcher), .issue1(issue1.dispatcher)
    );

    exec_lane #(.DEPTH_BITS(DEPTH_BITS)) lane0 (
        .clk(clk), .rst(rst), .issue(issue0.lane),
        .wb_valid(wb_valid[0]), .wb_idx(wb_idx[0]), .wb_entry(wb_entry[0])
    );

    exec_lane #(.DEPTH_BITS(DEPTH_BITS)) lane1 (
        .clk(clk), .rst(rst), .issue(issue1.lane),
        .wb_valid(wb_valid[1]), .wb_idx(wb_idx[1]), .wb_entry(wb_entry[1])
    );

    circular_queue #(.WIDTH(rob_entry_bits), .DEPTH(DEPTH), .DEPTH_BITS(DEPTH_BITS)) rob (
        .clk(clk), .rst(rst), .push(push), .pop(pop), .in(q_in),
        .reg_in(wb_entry), .reg_select_in(wb_idx), .reg_select_out(rd_idx),
        .in_bitmask(wb_valid), .out_bitmask(rd_mask),
        .empty(empty), .full(full), .out(q_out), .reg_out(rd_entry)
    );

    commit_unit #(.DEPTH_BITS(DEPTH_BITS)) commit (
        .clk(clk), .rst(rst), .reg_out(rd_entry), .out(q_out), .empty(empty),
        .reg_select_out(rd_idx), .out_bitmask(rd_mask), .pop(pop),
        .commit_valid(commit_valid),
        .commit_dest0(commit_dest0), .commit_value0(commit_value0),
        .commit_dest1(commit_dest1), .commit_value1(commit_value1)
    );

endmodule : dual_issue_rob

//--- sim/tb_dual_issue_rob.sv
`timescale 1ns/100ps

module tb_dual_issue_rob;
    import rv32i_types::*;

    localparam int burst_first = 3; // pairs 3 to 8 go out with no idle cycles between them
    localparam int burst_last = 8;
    localparam int pairs_in_queue = 4; // eight entries hold four pairs

    typedef struct packed {
        logic [2:0] op0;
        logic [xlen-1:0] a0;
        logic [xlen-1:0] b0;
        logic [reg_idx_bits-1:0] d0;
        logic [2:0] op1;
        logic [xlen-1:0] a1;
        logic [xlen-1:0] b1;
        logic [reg_idx_bits-1:0] d1;
    } pair_t;

    typedef struct packed {
        logic [reg_idx_bits-1:0] d0;
        logic [xlen-1:0] v0;
        logic [reg_idx_bits-1:0] d1;
        logic [xlen-1:0] v1;
    } result_t;

    logic clk;
    logic rst;
    logic dispatch_valid;
    logic dispatch_ready;
    alu_op_e op0;
    logic [xlen-1:0] src_a0;
    logic [xlen-1:0] src_b0;
    logic [reg_idx_bits-1:0] dest0;
    alu_op_e op1;
    logic [xlen-1:0] src_a1;
    logic [xlen-1:0] src_b1;
    logic [reg_idx_bits-1:0] dest1;
    logic commit_valid;
    logic [reg_idx_bits-1:0] commit_dest0;
    logic [xlen-1:0] commit_value0;
    logic [reg_idx_bits-1:0] commit_dest1;
    logic [xlen-1:0] commit_value1;

    pair_t pairs [$];
    result_t expected [$]; // results in acceptance order
    int errors = 0;
    int accept_count = 0;
    int commit_count = 0;
    int ready_low_cycles = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    dual_issue_rob #(.DEPTH(8), .DEPTH_BITS(3)) dut (
        .clk(clk), .rst(rst), .dispatch_valid(dispatch_valid), .dispatch_ready(dispatch_ready),
        .op0(op0), .src_a0(src_a0), .src_b0(src_b0), .dest0(dest0),
        .op1(op1), .src_a1(src_a1), .src_b1(src_b1), .dest1(dest1),
        .commit_valid(commit_valid), .commit_dest0(commit_dest0), .commit_value0(commit_value0),
        .commit_dest1(commit_dest1), .commit_value1(commit_value1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference ALU written from the RV32I rules
    function automatic logic [xlen-1:0] alu_expect(input alu_op_e op, input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
        logic [xlen-1:0] flip;
        flip = 32'h8000_0000; // flipping the sign bit turns a signed compare into an unsigned one
        case (op)
            op_add: return a + b;
            op_sub: return a - b;
            op_and: return a & b;
            op_or: return a | b;
            op_xor: return a ^ b;
            op_sll: return a << (b % 32);
            op_srl: return a >> (b % 32);
            default: return ((a ^ flip) < (b ^ flip)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic load_patterns();
        int fd;
        int n;
        int f [8];
        string line;
        pair_t p;
        fd = $fopen("sim/rob_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/rob_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin // lines with # describe the columns
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n == 8) begin
                    p.op0 = 3'(f[0]);
                    p.a0 = f[1];
                    p.b0 = f[2];
                    p.d0 = reg_idx_bits'(f[3]);
                    p.op1 = 3'(f[4]);
                    p.a1 = f[5];
                    p.b1 = f[6];
                    p.d1 = reg_idx_bits'(f[7]);
                    pairs.push_back(p);
                end
            end
        end
        $fclose(fd);
    endtask

    // holds the pair on the inputs until the edge that accepts it
    task automatic send_pair(input pair_t p);
        op0 <= alu_op_e'(p.op0);
        src_a0 <= p.a0;
        src_b0 <= p.b0;
        dest0 <= p.d0;
        op1 <= alu_op_e'(p.op1);
        src_a1 <= p.a1;
        src_b1 <= p.b1;
        dest1 <= p.d1;
        dispatch_valid <= 1'b1;
        @(posedge clk);
        while (!dispatch_ready) @(posedge clk);
    endtask

    task automatic record_pair();
        result_t r;
        r.d0 = dest0;
        r.v0 = alu_expect(op0, src_a0, src_b0);
        r.d1 = dest1;
        r.v1 = alu_expect(op1, src_a1, src_b1);
        expected.push_back(r);
        accept_count++;
    endtask

    task automatic check_commit();
        result_t e;
        assert (expected.size() > 0) else begin
            $display("commit at %0t with no accepted pair waiting for it", $time);
            errors++;
        end
        if (expected.size() > 0) begin
            e = expected.pop_front();
            assert (commit_dest0 == e.d0) else begin
                $display("FAIL t=%0t commit_dest0 expected %0d got %0d", $time, e.d0, commit_dest0);
                errors++;
            end
            assert (commit_value0 == e.v0) else begin
                $display("FAIL t=%0t commit_value0 expected %h got %h", $time, e.v0, commit_value0);
                errors++;
            end
            assert (commit_dest1 == e.d1) else begin
                $display("FAIL t=%0t commit_dest1 expected %0d got %0d", $time, e.d1, commit_dest1);
                errors++;
            end
            assert (commit_value1 == e.v1) else begin
                $display("FAIL t=%0t commit_value1 expected %h got %h", $time, e.v1, commit_value1);
                errors++;
            end
        end
        commit_count++;
    endtask

    // counters are read before this edge updates them, so the outstanding count matches full
    always @(posedge clk) begin
        if (!rst) begin
            if (!dispatch_ready) begin
                ready_low_cycles++;
                assert (accept_count - commit_count == pairs_in_queue) else begin
                    $display("dispatch_ready low at %0t with %0d pairs outstanding",
                             $time, accept_count - commit_count);
                    errors++;
                end
            end
            if (commit_valid) check_commit();
            if (dispatch_valid && dispatch_ready) record_pair();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d pairs committed",
                     cycle_count, commit_count, pairs.size());
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int gap;
        void'($urandom(32'h6dd4_f278));
        rst = 1'b1;
        dispatch_valid = 1'b0;
        op0 = op_add;
        src_a0 = '0;
        src_b0 = '0;
        dest0 = '0;
        op1 = op_add;
        src_a1 = '0;
        src_b1 = '0;
        dest1 = '0;
        load_patterns();
        cycle_limit = pairs.size() * 20 + 100;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (dispatch_ready) else begin
            $display("dispatch_ready is low right after reset");
            errors++;
        end
        for (int i = 0; i < pairs.size(); i++) begin
            send_pair(pairs[i]);
            gap = (i >= burst_first && i < burst_last) ? 0 : $urandom_range(3, 0);
            if (gap != 0) begin
                dispatch_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        dispatch_valid <= 1'b0;
        while (commit_count < pairs.size()) @(posedge clk);
        repeat (6) @(posedge clk); // room for a commit that should not be there
        assert (accept_count == pairs.size() && commit_count == accept_count) else begin
            $display("%0d pairs sent, %0d accepted, %0d committed",
                     pairs.size(), accept_count, commit_count);
            errors++;
        end
        assert (ready_low_cycles > 0) else begin
            $display("dispatch_ready never dropped during the burst");
            errors++;
        end
        $display("pairs committed: %0d of %0d, errors: %0d", commit_count, pairs.size(), errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_dual_issue_rob

//--- sim/rob_patterns.txt
# op0 a0 b0 dest0 op1 a1 b1 dest1, all in hex, one instruction pair per line
# opcodes 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 slt
0 00000005 00000007 01 1 00000010 00000003 02
2 f0f0f0f0 ff00ff00 03 3 0000000f 000000f0 04
4 aaaa5555 ffff0000 05 5 00000001 00000024 06
6 80000000 0000003f 07 7 fffffffe 00000001 08
7 00000003 fffffff0 09 7 80000000 7fffffff 0a
1 00000000 00000001 0b 0 ffffffff 00000001 0c
5 12345678 00000020 0d 6 deadbeef 00000104 0e
3 00000000 00000000 0f 2 12345678 ffffffff 10
7 ffffff00 ffffff01 11 4 5a5a5a5a a5a5a5a5 12
0 7fffffff 00000001 13 1 80000000 00000001 14
6 ffffffff 00000021 15 5 ffffffff 0000001f 16
7 00000005 00000005 17 0 00000123 00000456 1f

//--- flist.f
verilog/rv32i_types.sv
verilog/rob_pkg.sv
verilog/issue_if.sv
verilog/circular_queue.sv
verilog/dispatch_unit.sv
verilog/exec_lane.sv
verilog/commit_unit.sv
verilog/dual_issue_rob.sv
sim/tb_dual_issue_rob.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_dual_issue_rob \
    -f flist.f -o tb_dual_issue_rob
./obj_dir/tb_dual_issue_rob | tee sim.log
if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
